// File: include/bus_cfg.svh
`ifndef BUS_CFG_SVH
`define BUS_CFG_SVH

// Bus data and address width
`define BUS_DW 32

//////////////////////////////////////////////////
// Address map window bounds
//////////////////////////////////////////////////
// Data RAM low window starts at address zero
`define DRAM_LO_END   32'h0fff_ffff
`define VGA_REG_BASE  32'h1000_0000
`define VGA_REG_END   32'h1000_07ff
`define CURSOR_BASE   32'h1000_0800
`define CURSOR_END    32'h1000_0fff
`define TEXT_BASE     32'h1000_2000
`define TEXT_END      32'h1000_3fff
`define GRAPH_BASE    32'h1001_0000
`define GRAPH_END     32'h1001_ffff
`define IROM_BASE     32'h1fc0_0000
`define IROM_END      32'h1fff_ffff
// Data RAM high window runs to the top of the space
`define DRAM_HI_BASE  32'h2000_0000

// Word address widths of the shrunk memories
`define DRAM_AW  10
`define TEXT_AW  11
`define GRAPH_AW 12
`define IROM_AW  6

`endif

// File: design/bus_pkg.sv
`default_nettype none

package bus_pkg;

	// Master command, bit 0 reads and bit 1 writes
	// 2'b11 is illegal on the bus
	typedef enum logic [1:0] {
		RW_IDLE  = 2'b00,
		RW_READ  = 2'b01,
		RW_WRITE = 2'b10
	} rw_e;

	// Decoded slave target
	// Code 7 is never produced by the decoder
	typedef enum logic [2:0] {
		REG_NONE     = 3'd0,
		REG_DRAM     = 3'd1,
		REG_VGA_CTRL = 3'd2,
		REG_CURSOR   = 3'd3,
		REG_TEXT     = 3'd4,
		REG_GRAPH    = 3'd5,
		REG_IROM     = 3'd6
	} region_e;

endpackage

`default_nettype wire

// File: design/addr_decoder.sv
`default_nettype none
`include "bus_cfg.svh"

module addr_decoder (
	input  wire  [`BUS_DW-1:0] master_addr,
	output bus_pkg::region_e   region
);

	//////////////////////////////////////////////////
	// Window compare
	//////////////////////////////////////////////////
	always_comb begin
		// Low data RAM window starts at zero
		if (master_addr <= `DRAM_LO_END) begin
			region = bus_pkg::REG_DRAM;
		end else if (master_addr >= `VGA_REG_BASE && master_addr <= `VGA_REG_END) begin
			region = bus_pkg::REG_VGA_CTRL;
		end else if (master_addr >= `CURSOR_BASE && master_addr <= `CURSOR_END) begin
			region = bus_pkg::REG_CURSOR;
		end else if (master_addr >= `TEXT_BASE && master_addr <= `TEXT_END) begin
			region = bus_pkg::REG_TEXT;
		end else if (master_addr >= `GRAPH_BASE && master_addr <= `GRAPH_END) begin
			region = bus_pkg::REG_GRAPH;
		end else if (master_addr >= `IROM_BASE && master_addr <= `IROM_END) begin
			region = bus_pkg::REG_IROM;
		end else if (master_addr >= `DRAM_HI_BASE) begin
			// High alias of the same data RAM
			region = bus_pkg::REG_DRAM;
		end else begin
			// Holes between the peripheral windows
			region = bus_pkg::REG_NONE;
		end
	end

endmodule

`default_nettype wire

// File: design/bus.sv
`default_nettype none
`include "bus_cfg.svh"

module bus (
	input  wire                       clk,
	input  wire                       arst_n,
	input  wire  [`BUS_DW-1:0]        master_addr,
	input  wire  bus_pkg::rw_e        master_rw,
	input  wire  [`BUS_DW-1:0]        master_data_w,
	input  wire  bus_pkg::region_e    region,
	input  wire  [`BUS_DW-1:0]        irom_data_r,
	input  wire  [`BUS_DW-1:0]        dram_data_r,
	input  wire  [`BUS_DW-1:0]        text_data_r,
	input  wire  [`BUS_DW-1:0]        graph_data_r,
	input  wire  [`BUS_DW-1:0]        vga_reg_data_r,
	input  wire  [`BUS_DW-1:0]        cursor_data_r,
	output logic [`BUS_DW-1:0]        master_data_r,
	output logic [`IROM_AW-1:0]       irom_addr,
	output logic [`DRAM_AW-1:0]       dram_addr,
	output logic [`TEXT_AW-1:0]       text_addr,
	output logic [`GRAPH_AW-1:0]      graph_addr,
	output bus_pkg::rw_e              dram_rw,
	output bus_pkg::rw_e              text_rw,
	output bus_pkg::rw_e              graph_rw,
	output bus_pkg::rw_e              vga_reg_rw,
	output bus_pkg::rw_e              cursor_rw,
	output logic [`BUS_DW-1:0]        slave_data_w
);

	//////////////////////////////////////////////////
	// Address trim
	//////////////////////////////////////////////////
	// Drop byte offset and keep the word index of each window
	// Upper bits alias inside the shrunk memories
	assign irom_addr  = master_addr[`IROM_AW+1:2];
	assign dram_addr  = master_addr[`DRAM_AW+1:2];
	assign text_addr  = master_addr[`TEXT_AW+1:2];
	assign graph_addr = master_addr[`GRAPH_AW+1:2];

	//////////////////////////////////////////////////
	// Command gating
	//////////////////////////////////////////////////
	// Only the selected slave sees the master command
	assign dram_rw    = (region == bus_pkg::REG_DRAM) ? master_rw : bus_pkg::RW_IDLE;
	assign text_rw    = (region == bus_pkg::REG_TEXT) ? master_rw : bus_pkg::RW_IDLE;
	assign graph_rw   = (region == bus_pkg::REG_GRAPH) ? master_rw : bus_pkg::RW_IDLE;
	assign vga_reg_rw = (region == bus_pkg::REG_VGA_CTRL) ? master_rw : bus_pkg::RW_IDLE;
	assign cursor_rw  = (region == bus_pkg::REG_CURSOR) ? master_rw : bus_pkg::RW_IDLE;

	// Shared write data to every writable slave
	assign slave_data_w = master_data_w;

	//////////////////////////////////////////////////
	// Read data mux
	//////////////////////////////////////////////////
	always_comb begin
		master_data_r = '0;
		// Zero unless a read hits a mapped slave
		if (master_rw == bus_pkg::RW_READ) begin
			case (region)
				bus_pkg::REG_DRAM:     master_data_r = dram_data_r;
				bus_pkg::REG_VGA_CTRL: master_data_r = vga_reg_data_r;
				bus_pkg::REG_CURSOR:   master_data_r = cursor_data_r;
				bus_pkg::REG_TEXT:     master_data_r = text_data_r;
				bus_pkg::REG_GRAPH:    master_data_r = graph_data_r;
				bus_pkg::REG_IROM:     master_data_r = irom_data_r;
				default:               master_data_r = '0;
			endcase
		end
	end

	// Master never issues read and write together
	a_rw_legal: assert property (@(posedge clk) disable iff (!arst_n)
		master_rw inside {bus_pkg::RW_IDLE, bus_pkg::RW_READ, bus_pkg::RW_WRITE});

endmodule

`default_nettype wire

// File: design/word_ram.sv
`default_nettype none
`include "bus_cfg.svh"

module word_ram #(
	parameter int AW = 10
) (
	input  wire                clk,
	input  wire  bus_pkg::rw_e rw,
	input  wire  [AW-1:0]      addr,
	input  wire  [`BUS_DW-1:0] data_w,
	output logic [`BUS_DW-1:0] data_r
);

	//////////////////////////////////////////////////
	// Storage
	//////////////////////////////////////////////////
	// One word per address, contents undefined after power up
	logic [`BUS_DW-1:0] mem [2**AW];

	// Write commits on the edge that ends the command cycle
	always_ff @(posedge clk) begin
		if (rw == bus_pkg::RW_WRITE) begin
			mem[addr] <= data_w;
		end
	end

	// Asynchronous read, bus gates it by region
	assign data_r = mem[addr];

endmodule

`default_nettype wire

// File: design/boot_rom.sv
`default_nettype none
`include "bus_cfg.svh"

module boot_rom (
	input  wire  [`IROM_AW-1:0] addr,
	output logic [`BUS_DW-1:0]  data_r
);

	//////////////////////////////////////////////////
	// Boot image
	//////////////////////////////////////////////////
	// Fixed table of contents, rest is filler
	localparam logic [`BUS_DW-1:0] BOOT_W0 = 32'h3c1d_1000;
	localparam logic [`BUS_DW-1:0] BOOT_W1 = 32'h27bd_0ff0;
	localparam logic [`BUS_DW-1:0] BOOT_W2 = 32'h0bf0_0010;

	always_comb begin
		case (addr)
			// Stack pointer setup, upper half
			`IROM_AW'd0: data_r = BOOT_W0;
			// Stack pointer setup, lower half
			`IROM_AW'd1: data_r = BOOT_W1;
			// Jump into the loaded program
			`IROM_AW'd2: data_r = BOOT_W2;
			// Filler word equals its own byte address
			default: data_r = {{(`BUS_DW-`IROM_AW-2){1'b0}}, addr, 2'b00};
		endcase
	end

endmodule

`default_nettype wire

// File: design/vga_ctrl_regs.sv
`default_nettype none
`include "bus_cfg.svh"

module vga_ctrl_regs (
	input  wire                clk,
	input  wire                arst_n,
	input  wire  bus_pkg::rw_e vga_reg_rw,
	input  wire  bus_pkg::rw_e cursor_rw,
	input  wire  [`BUS_DW-1:0] data_w,
	output logic [`BUS_DW-1:0] vga_reg_data_r,
	output logic [`BUS_DW-1:0] cursor_data_r
);

	// Control register fields
	logic [2:0] vga_mode;
	logic       vga_enable;

	// Cursor register fields
	logic [6:0] cursor_col;
	logic [4:0] cursor_row;
	logic       cursor_blink;

	//////////////////////////////////////////////////
	// Control register
	//////////////////////////////////////////////////
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			vga_mode   <= '0;
			vga_enable <= 1'b0;
		end else if (vga_reg_rw == bus_pkg::RW_WRITE) begin
			// Mode in 2..0, enable in 31
			vga_mode   <= data_w[2:0];
			vga_enable <= data_w[31];
		end
	end

	// Unused bits read back as zero
	assign vga_reg_data_r = {vga_enable, 28'b0, vga_mode};

	//////////////////////////////////////////////////
	// Cursor register
	//////////////////////////////////////////////////
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cursor_col   <= '0;
			cursor_row   <= '0;
			cursor_blink <= 1'b0;
		end else if (cursor_rw == bus_pkg::RW_WRITE) begin
			cursor_col   <= data_w[6:0];
			cursor_row   <= data_w[12:8];
			cursor_blink <= data_w[16];
		end
	end

	// Column 6..0, row 12..8, blink 16
	assign cursor_data_r = {15'b0, cursor_blink, 3'b0, cursor_row, 1'b0, cursor_col};

	// Bus decode never targets both registers at once
	a_no_dual_write: assert property (@(posedge clk) disable iff (!arst_n)
		!(vga_reg_rw == bus_pkg::RW_WRITE && cursor_rw == bus_pkg::RW_WRITE));

endmodule

`default_nettype wire

// File: design/soc_bus_top.sv
`default_nettype none
`include "bus_cfg.svh"

module soc_bus_top (
	input  wire                clk,
	input  wire                arst_n,
	input  wire  [`BUS_DW-1:0] master_addr,
	input  wire  bus_pkg::rw_e master_rw,
	input  wire  [`BUS_DW-1:0] master_data_w,
	output logic [`BUS_DW-1:0] master_data_r
);

	// Decoded target
	bus_pkg::region_e region;

	// Per slave commands
	bus_pkg::rw_e dram_rw;
	bus_pkg::rw_e text_rw;
	bus_pkg::rw_e graph_rw;
	bus_pkg::rw_e vga_reg_rw;
	bus_pkg::rw_e cursor_rw;

	// Trimmed word addresses
	logic [`IROM_AW-1:0]  irom_addr;
	logic [`DRAM_AW-1:0]  dram_addr;
	logic [`TEXT_AW-1:0]  text_addr;
	logic [`GRAPH_AW-1:0] graph_addr;

	// Write data and slave read data
	logic [`BUS_DW-1:0] slave_data_w;
	logic [`BUS_DW-1:0] irom_data_r;
	logic [`BUS_DW-1:0] dram_data_r;
	logic [`BUS_DW-1:0] text_data_r;
	logic [`BUS_DW-1:0] graph_data_r;
	logic [`BUS_DW-1:0] vga_reg_data_r;
	logic [`BUS_DW-1:0] cursor_data_r;

	//////////////////////////////////////////////////
	// Decode and interconnect
	//////////////////////////////////////////////////
	addr_decoder u_addr_decoder (
		.master_addr (master_addr),
		.region      (region)
	);

	bus u_bus (
		.clk            (clk),
		.arst_n         (arst_n),
		.master_addr    (master_addr),
		.master_rw      (master_rw),
		.master_data_w  (master_data_w),
		.region         (region),
		.irom_data_r    (irom_data_r),
		.dram_data_r    (dram_data_r),
		.text_data_r    (text_data_r),
		.graph_data_r   (graph_data_r),
		.vga_reg_data_r (vga_reg_data_r),
		.cursor_data_r  (cursor_data_r),
		.master_data_r  (master_data_r),
		.irom_addr      (irom_addr),
		.dram_addr      (dram_addr),
		.text_addr      (text_addr),
		.graph_addr     (graph_addr),
		.dram_rw        (dram_rw),
		.text_rw        (text_rw),
		.graph_rw       (graph_rw),
		.vga_reg_rw     (vga_reg_rw),
		.cursor_rw      (cursor_rw),
		.slave_data_w   (slave_data_w)
	);

	//////////////////////////////////////////////////
	// Slaves
	//////////////////////////////////////////////////
	// Data RAM, reached from both aliased windows
	word_ram #(.AW(`DRAM_AW)) u_dram (
		.clk    (clk),
		.rw     (dram_rw),
		.addr   (dram_addr),
		.data_w (slave_data_w),
		.data_r (dram_data_r)
	);

	word_ram #(.AW(`TEXT_AW)) u_text_ram (
		.clk    (clk),
		.rw     (text_rw),
		.addr   (text_addr),
		.data_w (slave_data_w),
		.data_r (text_data_r)
	);

	word_ram #(.AW(`GRAPH_AW)) u_graph_ram (
		.clk    (clk),
		.rw     (graph_rw),
		.addr   (graph_addr),
		.data_w (slave_data_w),
		.data_r (graph_data_r)
	);

	// Read only, no command port
	boot_rom u_boot_rom (
		.addr   (irom_addr),
		.data_r (irom_data_r)
	);

	vga_ctrl_regs u_vga_ctrl_regs (
		.clk            (clk),
		.arst_n         (arst_n),
		.vga_reg_rw     (vga_reg_rw),
		.cursor_rw      (cursor_rw),
		.data_w         (slave_data_w),
		.vga_reg_data_r (vga_reg_data_r),
		.cursor_data_r  (cursor_data_r)
	);

endmodule

`default_nettype wire

// File: tests/tb_soc_bus.sv
`default_nettype none
`include "bus_cfg.svh"

module tb_soc_bus;

	// Half of the 40 unit clock period
	localparam int HALF_PERIOD   = 20;
	localparam int RESET_CYCLES  = 3;
	localparam int RESET_TIMEOUT = 50;
	// Random words per RAM
	localparam int RAM_WORDS     = 16;

	logic               clk;
	logic               arst_n;
	logic [`BUS_DW-1:0] master_addr;
	bus_pkg::rw_e       master_rw;
	logic [`BUS_DW-1:0] master_data_w;
	wire  [`BUS_DW-1:0] master_data_r;

	logic [31:0] lfsr_state;

	// Memory models with the word index wrapping at each depth
	logic [`BUS_DW-1:0] dram_model  [2**`DRAM_AW];
	logic [`BUS_DW-1:0] text_model  [2**`TEXT_AW];
	logic [`BUS_DW-1:0] graph_model [2**`GRAPH_AW];

	soc_bus_top UUT (
		.clk           (clk),
		.arst_n        (arst_n),
		.master_addr   (master_addr),
		.master_rw     (master_rw),
		.master_data_w (master_data_w),
		.master_data_r (master_data_r)
	);

	always #HALF_PERIOD clk = ~clk;

	// Reset held for three cycles and released on a falling edge
	initial begin
		arst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
	end

	//////////////////////////////////////////////////
	// Random source and checking
	//////////////////////////////////////////////////
	// Galois form with taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// One LFSR step per bit taken
	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
	endtask

	task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
		input string what);
		if (got !== exp) begin
			$display("Mismatch at time %0t: %s, got %h expected %h", $time, what, got, exp);
			$display("STATUS: FAIL");
			$fatal(1, "Value check failed");
		end
	endtask

	// Boot image of three fixed words then byte address filler
	function automatic logic [31:0] rom_word(input logic [31:0] k);
		case (k)
			32'd0: return 32'h3c1d_1000;
			32'd1: return 32'h27bd_0ff0;
			32'd2: return 32'h0bf0_0010;
			default: return k << 2;
		endcase
	endfunction

	//////////////////////////////////////////////////
	// Bus cycles
	//////////////////////////////////////////////////
	// Write commits on the rising edge closing the cycle
	task automatic write_word(input logic [31:0] addr, input logic [31:0] data);
		@(negedge clk);
		master_addr   = addr;
		master_rw     = bus_pkg::RW_WRITE;
		master_data_w = data;
		@(posedge clk);
	endtask

	// Read data is combinational and sampled at the closing edge
	task automatic read_word(input logic [31:0] addr, output logic [31:0] data);
		@(negedge clk);
		master_addr   = addr;
		master_rw     = bus_pkg::RW_READ;
		master_data_w = '0;
		@(posedge clk);
		data = master_data_r;
	endtask

	task automatic idle_read(input logic [31:0] addr, output logic [31:0] data);
		@(negedge clk);
		master_addr = addr;
		master_rw   = bus_pkg::RW_IDLE;
		@(posedge clk);
		data = master_data_r;
	endtask

	//////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////
	task automatic reset_values_read();
		logic [31:0] got;
		read_word(`VGA_REG_BASE, got);
		check_equal(got, 32'h0, "control register after reset");
		read_word(`CURSOR_BASE, got);
		check_equal(got, 32'h0, "cursor register after reset");
	endtask

	task automatic ram_readback();
		logic [31:0] r;
		logic [31:0] data;
		logic [31:0] addr;
		logic [31:0] got;
		for (int i = 0; i < RAM_WORDS; i++) begin
			// Text RAM offsets fill the window exactly
			take_bits(`TEXT_AW, r);
			take_bits(32, data);
			addr = `TEXT_BASE + (r << 2);
			write_word(addr, data);
			text_model[((addr - `TEXT_BASE) >> 2) % (2**`TEXT_AW)] = data;
			read_word(addr, got);
			check_equal(got, text_model[((addr - `TEXT_BASE) >> 2) % (2**`TEXT_AW)],
				"text RAM readback");
			// Graphics RAM window is four times the depth
			take_bits(14, r);
			take_bits(32, data);
			addr = `GRAPH_BASE + (r << 2);
			write_word(addr, data);
			graph_model[((addr - `GRAPH_BASE) >> 2) % (2**`GRAPH_AW)] = data;
			read_word(addr, got);
			check_equal(got, graph_model[((addr - `GRAPH_BASE) >> 2) % (2**`GRAPH_AW)],
				"graphics RAM readback");
			// Data RAM anywhere in the low window
			take_bits(26, r);
			take_bits(32, data);
			addr = r << 2;
			write_word(addr, data);
			dram_model[(addr >> 2) % (2**`DRAM_AW)] = data;
			read_word(addr, got);
			check_equal(got, dram_model[(addr >> 2) % (2**`DRAM_AW)], "data RAM readback");
		end
	endtask

	task automatic dram_alias();
		logic [31:0] off;
		logic [31:0] data;
		logic [31:0] got;
		for (int i = 0; i < 4; i++) begin
			take_bits(`DRAM_AW, off);
			off = off << 2;
			take_bits(32, data);
			write_word(`DRAM_HI_BASE + off, data);
			dram_model[off >> 2] = data;
			read_word(off, got);
			check_equal(got, dram_model[off >> 2], "high window write seen in low window");
			// One full depth higher is 4 KiB of words
			read_word(off + 32'h0000_1000, got);
			check_equal(got, dram_model[off >> 2], "alias above data RAM depth");
			read_word(32'h3000_0000 + off, got);
			check_equal(got, dram_model[off >> 2], "alias inside high window");
		end
	endtask

	task automatic boot_rom_image();
		logic [31:0] got;
		logic [31:0] data;
		for (int k = 0; k < 8; k++) begin
			read_word(`IROM_BASE + 32'(k << 2), got);
			check_equal(got, rom_word(32'(k)), "boot ROM word");
		end
		read_word(`IROM_BASE + 32'd252, got);
		check_equal(got, rom_word(32'd63), "boot ROM last word");
		// Word 64 wraps back onto word 0
		read_word(`IROM_BASE + 32'd256, got);
		check_equal(got, rom_word(32'd0), "boot ROM alias");
		// Data RAM words sharing the word index of the ROM writes
		write_word(32'h0000_0000, 32'h0bad_0000);
		dram_model[0] = 32'h0bad_0000;
		write_word(32'h0000_0004, 32'h0bad_0004);
		dram_model[1] = 32'h0bad_0004;
		take_bits(32, data);
		write_word(`IROM_BASE, data);
		write_word(`IROM_BASE + 32'd4, ~data);
		read_word(`IROM_BASE, got);
		check_equal(got, rom_word(32'd0), "boot ROM word 0 after write");
		read_word(`IROM_BASE + 32'd4, got);
		check_equal(got, rom_word(32'd1), "boot ROM word 1 after write");
		read_word(32'h0000_0000, got);
		check_equal(got, dram_model[0], "data RAM word 0 after boot ROM write");
		read_word(32'h0000_0004, got);
		check_equal(got, dram_model[1], "data RAM word 1 after boot ROM write");
	endtask

	task automatic reg_field_masks();
		logic [31:0] got;
		logic [31:0] data;
		write_word(`VGA_REG_BASE, 32'hffff_ffff);
		read_word(`VGA_REG_BASE, got);
		check_equal(got, 32'h8000_0007, "control register mask");
		write_word(`CURSOR_BASE, 32'hffff_ffff);
		read_word(`CURSOR_BASE, got);
		check_equal(got, 32'h0001_1f7f, "cursor register mask");
		// Random patterns keep mode 2..0 and enable 31
		take_bits(32, data);
		write_word(`VGA_REG_BASE + 32'h10, data);
		read_word(`VGA_REG_BASE, got);
		check_equal(got, data & 32'h8000_0007, "control register random write");
		// Cursor keeps column 6..0, row 12..8 and blink 16
		take_bits(32, data);
		write_word(`CURSOR_BASE + 32'h20, data);
		read_word(`CURSOR_BASE, got);
		check_equal(got, data & 32'h0001_1f7f, "cursor register random write");
	endtask

	task automatic gap_gating();
		logic [31:0] got;
		logic [31:0] data;
		logic [31:0] ctrl_saved;
		logic [31:0] cursor_saved;
		// Words the gap address would land on if gating leaked
		write_word(32'h0000_0000, 32'h1111_2222);
		dram_model[0] = 32'h1111_2222;
		write_word(`TEXT_BASE + 32'h1000, 32'h3333_4444);
		text_model[32'h400] = 32'h3333_4444;
		write_word(`GRAPH_BASE + 32'h1000, 32'h5555_6666);
		graph_model[32'h400] = 32'h5555_6666;
		read_word(`VGA_REG_BASE, ctrl_saved);
		read_word(`CURSOR_BASE, cursor_saved);
		read_word(32'h1000_1000, got);
		check_equal(got, 32'h0, "unmapped read");
		read_word(32'h1800_0000, got);
		check_equal(got, 32'h0, "unmapped read below boot ROM");
		take_bits(32, data);
		write_word(32'h1000_1000, data);
		read_word(32'h0000_0000, got);
		check_equal(got, dram_model[0], "data RAM after gap write");
		read_word(`TEXT_BASE + 32'h1000, got);
		check_equal(got, text_model[32'h400], "text RAM after gap write");
		read_word(`GRAPH_BASE + 32'h1000, got);
		check_equal(got, graph_model[32'h400], "graphics RAM after gap write");
		read_word(`VGA_REG_BASE, got);
		check_equal(got, ctrl_saved, "control register after gap write");
		read_word(`CURSOR_BASE, got);
		check_equal(got, cursor_saved, "cursor register after gap write");
		// Idle cycles return zero even on a mapped slave
		idle_read(32'h0000_0000, got);
		check_equal(got, 32'h0, "idle read of data RAM");
		idle_read(`IROM_BASE, got);
		check_equal(got, 32'h0, "idle read of boot ROM");
	endtask

	//////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////
	initial begin
		int wait_cycles;
		clk           = 1'b0;
		master_addr   = '0;
		master_rw     = bus_pkg::RW_IDLE;
		master_data_w = '0;
		lfsr_state    = 32'hcaec0e77;
		wait_cycles   = 0;
		while (arst_n !== 1'b1) begin
			@(negedge clk);
			wait_cycles++;
			if (wait_cycles > RESET_TIMEOUT) begin
				$display("STATUS: FAIL");
				$fatal(1, "Reset was not released within %0d cycles", RESET_TIMEOUT);
			end
		end
		reset_values_read();
		ram_readback();
		dram_alias();
		boot_rom_image();
		reg_field_masks();
		gap_gating();
		$display("STATUS: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
+incdir+include
design/bus_pkg.sv
design/addr_decoder.sv
design/bus.sv
design/word_ram.sv
design/boot_rom.sv
design/vga_ctrl_regs.sv
design/soc_bus_top.sv
tests/tb_soc_bus.sv

// File: Makefile
# Verilator build and run of the SoC bus testbench
# Any variable can be overridden, e.g. make test BUILD_DIR=build

VERILATOR ?= verilator
TOP       ?= tb_soc_bus
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the simulation, fails on a failing test"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR JOBS VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
